//--- Makefile
# Verilator build and run for the width conversion testbench

VERILATOR ?= verilator
TOP       ?= tb_width_conv
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST RESULT: PASS

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard include/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- include/bench_defs.svh
// Testbench constants for the width conversion bench
// Packet count, random seed, clock period and watchdog limit
// Field check task with mismatch reporting

`ifndef BENCH_DEFS_SVH
`define BENCH_DEFS_SVH

localparam int unsigned tb_num_packets = 200;
localparam int tb_seed = 80;
localparam int unsigned tb_clk_period_ns = 20;
localparam int unsigned tb_max_pkt_beats = 11;

// Allow 12 beats per packet and 4 cycles per beat before giving up
localparam int unsigned tb_timeout_cycles = tb_num_packets * 12 * 4;
localparam int unsigned tb_timeout_ns = tb_timeout_cycles * tb_clk_period_ns;

// Compares one field and counts a mismatch
task automatic check_field(
    input string           name,
    input logic [127:0]    exp_val,
    input logic [127:0]    act_val,
    inout int unsigned     err_cnt
);
    if (exp_val !== act_val) begin
        err_cnt++;
        $display("Fail %s expected %0h actual %0h", name, exp_val, act_val);
    end
endtask

`endif

//--- bench/tb_width_conv.sv
// Testbench for the narrow to wide to narrow stream path
// Random packets with gaps and output stalls, reference queue and comparison
// Includes a reset check and a watchdog

`timescale 1ns/1ps
`default_nettype none

module tb_width_conv;

    `include "bench_defs.svh"

    // The first packets run with no gaps and out_ready held high
    localparam int unsigned calm_packets = tb_num_packets / 5;

    typedef struct packed {
        axis_pkg::narrow_beat_t beat;
        axis_pkg::meta_t        meta;
    } expect_t;

    logic                   from_tx;
    logic                   rst_n;
    axis_pkg::narrow_beat_t in_beat;
    axis_pkg::meta_t        in_meta;
    logic                   in_valid;
    logic                   in_ready;
    axis_pkg::narrow_beat_t out_beat;
    axis_pkg::meta_t        out_meta;
    logic                   out_valid;
    logic                   out_ready;

    integer      stim_seed = tb_seed;
    integer      sink_seed = tb_seed + 1;
    bit          stress = 1'b0;
    bit          in_sop = 1'b1;
    bit          reset_checked = 1'b0;
    int unsigned err_cnt = 0;
    int unsigned misc_cnt = 0;
    int unsigned sent_cnt = 0;
    int unsigned rcv_cnt = 0;
    axis_pkg::meta_t pkt_meta;
    expect_t     exp_q[$];

    width_conv_top i_width_conv_top (
        .from_tx   (from_tx),
        .rst_n     (rst_n),
        .in_beat   (in_beat),
        .in_meta   (in_meta),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_meta  (out_meta),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    // Each narrow beat comes back unchanged and tagged with its packet's first metadata
    function automatic expect_t expected_out(input axis_pkg::narrow_beat_t beat,
                                             input axis_pkg::meta_t first_meta);
        expect_t e;
        e.beat.data = beat.data;
        e.beat.keep = beat.keep;
        e.beat.last = beat.last;
        e.meta = first_meta;
        return e;
    endfunction

    // Contiguous low bytes for the final beat of a packet
    function automatic logic [3:0] low_keep_mask(input int width);
        logic [3:0] mask;
        for (int i = 0; i < 4; i++) begin
            mask[i] = (i < width);
        end
        return mask;
    endfunction

    initial begin
        from_tx = 1'b0;
        forever #(tb_clk_period_ns / 2) from_tx = ~from_tx;
    end

    initial begin : drive_source
        axis_pkg::narrow_beat_t beat;
        axis_pkg::meta_t meta;
        int len;
        int tail;
        int gap;
        bit end_fail;
        end_fail = 1'b0;
        rst_n <= 1'b0;
        in_beat <= '0;
        in_meta <= '0;
        in_valid <= 1'b0;
        repeat (8) @(posedge from_tx);
        rst_n <= 1'b1;
        @(posedge from_tx);
        for (int unsigned pkt = 0; pkt < tb_num_packets; pkt++) begin
            stress = (pkt >= calm_packets);
            len = 1 + {$random(stim_seed)} % tb_max_pkt_beats;
            tail = 1 + {$random(stim_seed)} % 4;
            for (int b = 0; b < len; b++) begin
                if (stress && ({$random(stim_seed)} % 3) == 0) begin
                    in_valid <= 1'b0;
                    gap = 1 + {$random(stim_seed)} % 3;
                    repeat (gap) @(posedge from_tx);
                end
                beat.data = $random(stim_seed);
                beat.last = (b == len - 1);
                beat.keep = beat.last ? low_keep_mask(tail) : 4'hf;
                // Metadata changes on every beat so that latching is visible
                meta = 16'($random(stim_seed));
                in_beat <= beat;
                in_meta <= meta;
                in_valid <= 1'b1;
                do @(posedge from_tx); while (!in_ready);
            end
        end
        in_valid <= 1'b0;
        stress = 1'b0;
        while (exp_q.size() != 0) @(posedge from_tx);
        repeat (20) @(posedge from_tx);
        if (sent_cnt != rcv_cnt) begin
            end_fail = 1'b1;
            $display("Beat count differs: %0d sent and %0d received", sent_cnt, rcv_cnt);
        end
        $display("Errors: %0d value mismatches, %0d other failures, %0d beats checked",
                 err_cnt, misc_cnt + end_fail, rcv_cnt);
        if (err_cnt == 0 && misc_cnt == 0 && !end_fail) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Sink stalls only once the calm packets are through
    initial begin : drive_sink
        out_ready <= 1'b0;
        forever begin
            @(posedge from_tx);
            if (stress) begin
                out_ready <= ({$random(sink_seed)} % 4) != 0;
            end else begin
                out_ready <= 1'b1;
            end
        end
    end

    always @(posedge from_tx) begin : record_input
        if (rst_n && in_valid && in_ready) begin
            if (in_sop) begin
                pkt_meta = in_meta;
            end
            exp_q.push_back(expected_out(in_beat, pkt_meta));
            in_sop = in_beat.last;
            sent_cnt++;
        end
    end

    always @(posedge from_tx) begin : compare_output
        expect_t want;
        if (!rst_n) begin
            if (out_valid) begin
                misc_cnt++;
                $display("out_valid was high during reset");
            end
        end else begin
            if (!reset_checked) begin
                check_field("in_ready", 128'(1'b1), 128'(in_ready), err_cnt);
                reset_checked = 1'b1;
            end
            if (out_valid && sent_cnt == 0) begin
                misc_cnt++;
                $display("out_valid rose before any input beat was accepted");
            end
            if (out_valid && out_ready) begin
                rcv_cnt++;
                if (exp_q.size() == 0) begin
                    misc_cnt++;
                    $display("An output beat appeared with no input beat left to match");
                end else begin
                    want = exp_q.pop_front();
                    check_field("out_beat.data", 128'(want.beat.data), 128'(out_beat.data),
                                err_cnt);
                    check_field("out_beat.keep", 128'(want.beat.keep), 128'(out_beat.keep),
                                err_cnt);
                    check_field("out_beat.last", 128'(want.beat.last), 128'(out_beat.last),
                                err_cnt);
                    check_field("out_meta", 128'(want.meta), 128'(out_meta), err_cnt);
                end
            end
        end
    end

    initial begin : watchdog
        #(tb_timeout_ns);
        $display("Timeout: the run did not finish within %0d ns", tb_timeout_ns);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
logic/axis_pkg.sv
logic/stream_meta_hold.sv
logic/stream_skid_buffer.sv
logic/width_upsizer.sv
logic/width_downsizer.sv
logic/width_conv_top.sv
bench/tb_width_conv.sv

//--- logic/axis_pkg.sv
// Shared widths, ratio and packing constants for the width conversion path
// Stream beat and metadata struct types used across the datapath

`default_nettype none

package axis_pkg;

    // Narrow side is the external stream, wide side is the internal link
    localparam int narrow_bytes = 4;
    localparam int wide_bytes = 16;
    localparam int conv_ratio = wide_bytes / narrow_bytes;

    // Lane select width and pack counter width (counter must reach conv_ratio)
    localparam int lane_w = $clog2(conv_ratio);
    localparam int pack_cnt_w = $clog2(conv_ratio + 1);
    localparam logic [pack_cnt_w-1:0] pack_full = pack_cnt_w'(conv_ratio);

    // Metadata is held from the first beat of each packet when set
    localparam bit latch_meta_on_sop = 1'b1;

    typedef struct packed {
        logic [3:0] tid;
        logic [3:0] tdest;
        logic [7:0] tuser;
    } meta_t;

    // Byte 0 of the stream sits in data[7:0] and is enabled by keep[0]
    typedef struct packed {
        logic [narrow_bytes*8-1:0] data;
        logic [narrow_bytes-1:0]   keep;
        logic                      last;
    } narrow_beat_t;

    typedef struct packed {
        logic [wide_bytes*8-1:0] data;
        logic [wide_bytes-1:0]   keep;
        logic                    last;
    } wide_beat_t;

    // Payload carried through the wide skid stage
    typedef struct packed {
        wide_beat_t beat;
        meta_t      meta;
    } wide_xfer_t;

endpackage

`default_nettype wire

//--- logic/stream_meta_hold.sv
// Start-of-packet tracking and metadata register for stream converters
// Loads on the first beat of a packet, or on every beat in pass mode

`timescale 1ns/1ps
`default_nettype none

module stream_meta_hold #(
    parameter type meta_t = axis_pkg::meta_t,
    parameter bit latch_on_sop = axis_pkg::latch_meta_on_sop
) (
    input  wire logic  from_tx,
    input  wire logic  rst_n,
    input  wire logic  take,
    input  wire logic  last,
    input  wire meta_t meta_in,
    output meta_t      meta_out
);

    logic sop;
    logic load;

    // The next accepted beat opens a packet after reset and after any last
    always_ff @(posedge from_tx or negedge rst_n) begin
        if (!rst_n) begin
            sop <= 1'b1;
        end else if (take) begin
            sop <= last;
        end
    end

    // With latch_on_sop clear the register follows the most recent beat,
    // so a wide beat reports the metadata of its final narrow beat
    assign load = take && (sop || !latch_on_sop);

    always_ff @(posedge from_tx) begin
        if (load) begin
            meta_out <= meta_in;
        end
    end

endmodule

`default_nettype wire

//--- logic/stream_skid_buffer.sv
// Registered valid/ready pipeline stage with a one-entry skid register
// Input ready comes straight from a flop, output is fully registered

`timescale 1ns/1ps
`default_nettype none

module stream_skid_buffer #(
    parameter type payload_t = logic [7:0]
) (
    input  wire logic     from_tx,
    input  wire logic     rst_n,
    input  wire payload_t in_data,
    input  wire logic     in_valid,
    output logic          in_ready,
    output payload_t      out_data,
    output logic          out_valid,
    input  wire logic     out_ready
);

    payload_t skid_data;
    logic skid_full;
    logic in_take;
    logic out_free;

    assign in_ready = !skid_full;
    assign in_take = in_valid && in_ready;

    // The main register can load when it is empty or being drained
    assign out_free = out_ready || !out_valid;

    always_ff @(posedge from_tx or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            skid_full <= 1'b0;
        end else if (out_free) begin
            out_valid <= skid_full || in_take;
            skid_full <= 1'b0;
        end else if (in_take) begin
            // Ready was still high from last cycle, so park this beat
            skid_full <= 1'b1;
        end
    end

    always_ff @(posedge from_tx) begin
        if (out_free) begin
            if (skid_full) begin
                out_data <= skid_data;
            end else if (in_take) begin
                out_data <= in_data;
            end
        end else if (in_take) begin
            skid_data <= in_data;
        end
    end

    // A parked beat stays intact until the main register is free again
    a_skid_kept: assert property (@(posedge from_tx) disable iff (!rst_n)
        skid_full && !out_ready |=> skid_full && $stable(skid_data))
        else $error("skid entry overwritten while full");

endmodule

`default_nettype wire

//--- logic/width_conv_top.sv
// Narrow to wide to narrow stream path
// Upsizer, registered skid stage on the wide link, then downsizer

`timescale 1ns/1ps
`default_nettype none

module width_conv_top (
    input  wire logic                   from_tx,
    input  wire logic                   rst_n,
    input  wire axis_pkg::narrow_beat_t in_beat,
    input  wire axis_pkg::meta_t        in_meta,
    input  wire logic                   in_valid,
    output logic                        in_ready,
    output axis_pkg::narrow_beat_t      out_beat,
    output axis_pkg::meta_t             out_meta,
    output logic                        out_valid,
    input  wire logic                   out_ready
);

    axis_pkg::wide_beat_t up_to_skid_beat;
    axis_pkg::meta_t up_to_skid_meta;
    axis_pkg::wide_xfer_t up_to_skid;
    logic up_to_skid_valid;
    logic up_to_skid_ready;

    axis_pkg::wide_xfer_t skid_to_down;
    logic skid_to_down_valid;
    logic skid_to_down_ready;

    // Only whole multiples of the narrow width are handled
    if (axis_pkg::wide_bytes % axis_pkg::narrow_bytes != 0) begin : g_ratio_check
        $error("wide width is not a multiple of the narrow width");
    end

    width_upsizer i_width_upsizer (
        .from_tx    (from_tx),
        .rst_n      (rst_n),
        .in_beat    (in_beat),
        .in_meta    (in_meta),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .wide_beat  (up_to_skid_beat),
        .wide_meta  (up_to_skid_meta),
        .wide_valid (up_to_skid_valid),
        .wide_ready (up_to_skid_ready)
    );

    assign up_to_skid = '{beat: up_to_skid_beat, meta: up_to_skid_meta};

    stream_skid_buffer #(
        .payload_t (axis_pkg::wide_xfer_t)
    ) i_stream_skid_buffer (
        .from_tx   (from_tx),
        .rst_n     (rst_n),
        .in_data   (up_to_skid),
        .in_valid  (up_to_skid_valid),
        .in_ready  (up_to_skid_ready),
        .out_data  (skid_to_down),
        .out_valid (skid_to_down_valid),
        .out_ready (skid_to_down_ready)
    );

    width_downsizer i_width_downsizer (
        .from_tx    (from_tx),
        .rst_n      (rst_n),
        .wide_beat  (skid_to_down.beat),
        .wide_meta  (skid_to_down.meta),
        .wide_valid (skid_to_down_valid),
        .wide_ready (skid_to_down_ready),
        .out_beat   (out_beat),
        .out_meta   (out_meta),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

//--- logic/width_downsizer.sv
// Unpacks wide stream beats into narrow beats, lowest lane first
// Lanes without their first keep bit are skipped, last goes with the final lane

`timescale 1ns/1ps
`default_nettype none

module width_downsizer (
    input  wire logic                 from_tx,
    input  wire logic                 rst_n,
    input  wire axis_pkg::wide_beat_t wide_beat,
    input  wire axis_pkg::meta_t      wide_meta,
    input  wire logic                 wide_valid,
    output logic                      wide_ready,
    output axis_pkg::narrow_beat_t    out_beat,
    output axis_pkg::meta_t           out_meta,
    output logic                      out_valid,
    input  wire logic                 out_ready
);

    logic [axis_pkg::conv_ratio-1:0] lane_vld;
    logic [axis_pkg::conv_ratio-1:0] lane_map;
    logic [axis_pkg::conv_ratio-1:0][axis_pkg::narrow_bytes*8-1:0] data_q;
    logic [axis_pkg::conv_ratio-1:0][axis_pkg::narrow_bytes-1:0] keep_q;
    logic last_q;
    logic in_take;
    logic out_take;

    // A lane carries data when its lowest byte is kept
    always_comb begin
        for (int i = 0; i < axis_pkg::conv_ratio; i++) begin
            lane_map[i] = wide_beat.keep[i*axis_pkg::narrow_bytes];
        end
    end

    assign in_take = wide_valid && wide_ready;
    assign out_take = out_valid && out_ready;

    // Refill when empty, or when the only remaining lane leaves this cycle
    assign wide_ready = !lane_vld[0] || (!lane_vld[1] && out_ready);
    assign out_valid = lane_vld[0];

    always_ff @(posedge from_tx or negedge rst_n) begin
        if (!rst_n) begin
            lane_vld <= '0;
            last_q <= 1'b0;
        end else if (in_take) begin
            lane_vld <= lane_map;
            last_q <= wide_beat.last;
        end else if (out_take) begin
            lane_vld <= lane_vld >> 1;
        end
    end

    // Lane 0 always holds the beat on offer
    always_ff @(posedge from_tx) begin
        if (in_take) begin
            data_q <= wide_beat.data;
            keep_q <= wide_beat.keep;
        end else if (out_take) begin
            data_q <= data_q >> (axis_pkg::narrow_bytes * 8);
            keep_q <= keep_q >> axis_pkg::narrow_bytes;
        end
    end

    assign out_beat = '{data: data_q[0], keep: keep_q[0], last: last_q && !lane_vld[1]};

    stream_meta_hold #(
        .meta_t       (axis_pkg::meta_t),
        .latch_on_sop (axis_pkg::latch_meta_on_sop)
    ) i_meta_hold (
        .from_tx  (from_tx),
        .rst_n    (rst_n),
        .take     (in_take),
        .last     (wide_beat.last),
        .meta_in  (wide_meta),
        .meta_out (out_meta)
    );

    // Upstream keep must fill lanes from the bottom with no holes
    a_lanes_packed: assert property (@(posedge from_tx) disable iff (!rst_n)
        in_take |=> ((lane_vld + 1'b1) & lane_vld) == '0)
        else $error("downsizer loaded a valid lane above an empty one");

endmodule

`default_nettype wire

//--- logic/width_upsizer.sv
// Packs narrow stream beats into wide beats, lowest lane first
// Flushes early on last, clears unused lanes, holds metadata per packet

`timescale 1ns/1ps
`default_nettype none

module width_upsizer (
    input  wire logic                   from_tx,
    input  wire logic                   rst_n,
    input  wire axis_pkg::narrow_beat_t in_beat,
    input  wire axis_pkg::meta_t        in_meta,
    input  wire logic                   in_valid,
    output logic                        in_ready,
    output axis_pkg::wide_beat_t        wide_beat,
    output axis_pkg::meta_t             wide_meta,
    output logic                        wide_valid,
    input  wire logic                   wide_ready
);

    logic [axis_pkg::pack_cnt_w-1:0] pack_cnt;
    logic [axis_pkg::lane_w-1:0] lane_sel;
    logic [axis_pkg::conv_ratio-1:0][axis_pkg::narrow_bytes*8-1:0] data_q;
    logic [axis_pkg::conv_ratio-1:0][axis_pkg::narrow_bytes-1:0] keep_q;
    logic last_q;
    logic in_take;
    logic out_take;

    assign in_take = in_valid && in_ready;
    assign out_take = wide_valid && wide_ready;
    assign lane_sel = pack_cnt[axis_pkg::lane_w-1:0];

    // A wide beat is ready once all lanes are filled or the packet has ended
    assign wide_valid = (pack_cnt == axis_pkg::pack_full) || ((pack_cnt != '0) && last_q);
    assign in_ready = wide_ready || !wide_valid;

    // Lane count, keep lanes and last flag decide what the output shows
    always_ff @(posedge from_tx or negedge rst_n) begin
        if (!rst_n) begin
            pack_cnt <= '0;
            keep_q <= '0;
            last_q <= 1'b0;
        end else if (out_take) begin
            // Draining and accepting in one cycle starts the next beat in lane 0
            pack_cnt <= {{(axis_pkg::pack_cnt_w-1){1'b0}}, in_take};
            keep_q[axis_pkg::conv_ratio-1:1] <= '0;
            keep_q[0] <= in_take ? in_beat.keep : '0;
            if (in_take) begin
                last_q <= in_beat.last;
            end
        end else if (in_take) begin
            pack_cnt <= pack_cnt + 1'b1;
            keep_q[lane_sel] <= in_beat.keep;
            last_q <= in_beat.last;
        end
    end

    always_ff @(posedge from_tx) begin
        if (out_take) begin
            data_q[axis_pkg::conv_ratio-1:1] <= '0;
            if (in_take) begin
                data_q[0] <= in_beat.data;
            end
        end else if (in_take) begin
            data_q[lane_sel] <= in_beat.data;
        end
    end

    assign wide_beat = '{data: data_q, keep: keep_q, last: last_q};

    stream_meta_hold #(
        .meta_t       (axis_pkg::meta_t),
        .latch_on_sop (axis_pkg::latch_meta_on_sop)
    ) i_meta_hold (
        .from_tx  (from_tx),
        .rst_n    (rst_n),
        .take     (in_take),
        .last     (in_beat.last),
        .meta_in  (in_meta),
        .meta_out (wide_meta)
    );

    // A stalled wide beat and its metadata must not move until taken
    a_stall_stable: assert property (@(posedge from_tx) disable iff (!rst_n)
        wide_valid && !wide_ready |=> wide_valid && $stable(wide_beat) && $stable(wide_meta))
        else $error("upsizer output changed while stalled");

endmodule

`default_nettype wire
